// ==== rtl/qspi_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types and constants shared by the quad-SPI controller blocks
// referenced as qspi_pkg::name, never imported
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package qspi_pkg;

	typedef enum logic {
		op_read,
		op_write
	} qspi_op_e;

	typedef enum logic [1:0] {
		sz_byte,
		sz_half,
		sz_word
	} qspi_size_e;

	// 61 bits, one pending host access
	typedef struct packed {
		qspi_op_e   op;
		qspi_size_e size;
		logic [25:0] adr;
		logic [31:0] wdata;
	} qspi_req_t;

	typedef enum logic [2:0] {
		st_idle,
		st_cmd,
		st_adr,
		st_wdat,
		st_rwait,
		st_rdat
	} seq_state_e;

	localparam logic [7:0] cmd_fread_quad = 8'hEB;
	localparam logic [7:0] cmd_write_quad = 8'h38;

	// word offsets on the io bus
	localparam logic [13:0] reg_latency0 = 14'h3D00;
	localparam logic [13:0] reg_latency1 = 14'h3D01;
	localparam logic [13:0] reg_latency2 = 14'h3D02;
	localparam logic [13:0] reg_sckdiv   = 14'h3D03;

	localparam logic [9:0] sckdiv_default = 10'd3;

endpackage

// ==== rtl/qspi_req_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request link between front end, queue and sequencer
// valid and req travel forward, take comes back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface qspi_req_if;

	wire valid;
	wire take;
	wire qspi_pkg::qspi_req_t req;

	modport producer (
		output valid,
		output req,
		input  take
	);

	// the queue faces a producer on one link and a consumer on the other
	modport buffer (
		inout valid,
		inout req,
		inout take
	);

	modport consumer (
		input  valid,
		input  req,
		output take
	);

endinterface

// ==== rtl/qspi_host_front.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side of the controller
// turns read/write strobes into queued requests and
// formats read completions back into host byte order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_host_front #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic read_req,
	input  logic read_w,
	input  logic read_hw,
	input  logic [31:0] read_adr,
	input  logic write_req,
	input  logic write_w,
	input  logic write_hw,
	input  logic [31:0] write_adr,
	input  logic [31:0] write_data,
	input  logic [31:0] rdata_raw,
	input  logic done_read,
	input  logic done_write,
	output logic read_valid,
	output logic [31:0] read_data,
	output logic write_finish,
	qspi_req_if.producer req_out
);

	// one extra slot for the read that is already on the bus
	localparam int SIZE_DEPTH = QUEUE_DEPTH + 1;
	localparam int SW = $clog2(SIZE_DEPTH);

	logic req_valid;
	qspi_pkg::qspi_req_t req_q;
	qspi_pkg::qspi_req_t req_pre;
	qspi_pkg::qspi_size_e size_mem [SIZE_DEPTH];
	logic [SW-1:0] size_wr_ptr;
	logic [SW-1:0] size_rd_ptr;
	qspi_pkg::qspi_size_e size_head;
	logic size_push;

	// read has priority when both strobes arrive together
	always_comb begin
		if (read_req) begin
			req_pre.op = qspi_pkg::op_read;
			req_pre.size = read_w ? qspi_pkg::sz_word :
			               read_hw ? qspi_pkg::sz_half : qspi_pkg::sz_byte;
			req_pre.adr = read_adr[25:0];
		end else begin
			req_pre.op = qspi_pkg::op_write;
			req_pre.size = write_w ? qspi_pkg::sz_word :
			               write_hw ? qspi_pkg::sz_half : qspi_pkg::sz_byte;
			req_pre.adr = write_adr[25:0];
		end
		req_pre.wdata = write_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= read_req | write_req;
		end
	end

	always_ff @(posedge clk) begin
		if (read_req | write_req) begin
			req_q <= req_pre;
		end
	end

	assign req_out.valid = req_valid;
	assign req_out.req = req_q;

	// sizes of accepted reads, in issue order
	assign size_push = req_out.take & (req_q.op == qspi_pkg::op_read);

	always_ff @(posedge clk) begin
		if (size_push) begin
			size_mem[size_wr_ptr] <= req_q.size;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			size_wr_ptr <= '0;
			size_rd_ptr <= '0;
		end else begin
			if (size_push) begin
				size_wr_ptr <= (size_wr_ptr == SW'(SIZE_DEPTH - 1)) ? '0 : size_wr_ptr + 1'b1;
			end
			if (done_read) begin
				size_rd_ptr <= (size_rd_ptr == SW'(SIZE_DEPTH - 1)) ? '0 : size_rd_ptr + 1'b1;
			end
		end
	end

	assign size_head = size_mem[size_rd_ptr];

	// first byte on the wire lands in the top byte of rdata_raw
	always_comb begin
		case (size_head)
			qspi_pkg::sz_word: read_data = {rdata_raw[7:0], rdata_raw[15:8],
			                                rdata_raw[23:16], rdata_raw[31:24]};
			qspi_pkg::sz_half: read_data = {16'd0, rdata_raw[7:0], rdata_raw[15:8]};
			default:           read_data = {24'd0, rdata_raw[7:0]};
		endcase
	end

	assign read_valid = done_read;
	assign write_finish = done_write;

endmodule

// ==== rtl/qspi_req_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular FIFO of pending requests
// head is offered whenever the FIFO holds an entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_req_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	qspi_req_if.buffer push_side,
	qspi_req_if.buffer pop_side,
	output logic full
);

	localparam int AW = $clog2(QUEUE_DEPTH);
	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	qspi_pkg::qspi_req_t mem [QUEUE_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;
	logic not_empty;

	assign not_empty = (count != '0);
	assign full = (count == CW'(QUEUE_DEPTH));

	// a strobe while full is a host error and is not stored
	assign push = push_side.valid & ~full;
	assign pop = pop_side.take & not_empty;

	assign push_side.take = push;
	assign pop_side.valid = not_empty;
	assign pop_side.req = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_side.req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== rtl/qspi_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quad-SPI bus sequencer
// runs one request at a time: command, address, then
// write nibbles or wait cycles and read nibbles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_sequencer (
	input  logic clk,
	input  logic rst_n,
	qspi_req_if.consumer req_in,
	input  logic [3:0] latency0,
	input  logic [3:0] latency1,
	input  logic [3:0] latency2,
	input  logic [9:0] sck_div,
	output logic sck,
	output logic [2:0] ce_n,
	output logic [3:0] sio_out,
	output logic sio_oe,
	input  logic [3:0] sio_in,
	output logic [31:0] rdata_raw,
	output logic done_read,
	output logic done_write
);

	logic [9:0] sck_cntr;
	logic half_sck;
	logic fall_tick;
	logic [3:0] sio_mt0;
	logic [3:0] sio_mt1;
	logic [3:0] sio_sync;
	logic take_req;
	logic busy;
	qspi_pkg::qspi_req_t cur;
	qspi_pkg::seq_state_e state;
	qspi_pkg::seq_state_e next_state;
	logic [3:0] cnt;
	logic [3:0] cnt_load;
	logic cnt_zero;
	logic [3:0] latency_sel;
	logic read_data_end;
	logic write_data_end;
	logic [7:0] cmd_byte;
	logic [31:0] ext_wdata;
	logic [3:0] sio_out_pre;
	logic sio_oe_pre;
	logic [31:0] word_data;

	// nibble count minus one for each access size
	function automatic logic [3:0] nib_len(input qspi_pkg::qspi_size_e sz);
		case (sz)
			qspi_pkg::sz_word: nib_len = 4'd7;
			qspi_pkg::sz_half: nib_len = 4'd3;
			default:           nib_len = 4'd1;
		endcase
	endfunction

	// half period of sck is sck_div+1 clocks
	assign half_sck = (sck_cntr >= sck_div);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_cntr <= 10'd0;
			sck <= 1'b1;
		end else if (half_sck) begin
			sck_cntr <= 10'd0;
			sck <= ~sck;
		end else begin
			sck_cntr <= sck_cntr + 10'd1;
		end
	end

	// sck falls on the same clock edge as the state update
	assign fall_tick = half_sck & sck;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_mt0 <= 4'h0;
			sio_mt1 <= 4'h0;
			sio_sync <= 4'h0;
		end else begin
			sio_mt0 <= sio_in;
			sio_mt1 <= sio_mt0;
			sio_sync <= sio_mt1;
		end
	end

	assign take_req = (state == qspi_pkg::st_idle) & ~busy & req_in.valid;
	assign req_in.take = take_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (take_req) begin
			busy <= 1'b1;
		end else if (read_data_end | write_data_end) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_req) begin
			cur <= req_in.req;
		end
	end

	always_comb begin
		case (cur.adr[25:24])
			2'd1:    latency_sel = latency1;
			2'd2:    latency_sel = latency2;
			default: latency_sel = latency0;
		endcase
	end

	assign cnt_zero = (cnt == 4'd0);

	always_comb begin
		next_state = state;
		case (state)
			qspi_pkg::st_idle:
				if (busy) next_state = qspi_pkg::st_cmd;
			qspi_pkg::st_cmd:
				if (cnt_zero) next_state = qspi_pkg::st_adr;
			qspi_pkg::st_adr:
				if (cnt_zero) begin
					next_state = (cur.op == qspi_pkg::op_read) ? qspi_pkg::st_rwait :
					                                             qspi_pkg::st_wdat;
				end
			qspi_pkg::st_wdat:
				if (cnt_zero) next_state = qspi_pkg::st_idle;
			qspi_pkg::st_rwait:
				if (cnt_zero) next_state = qspi_pkg::st_rdat;
			qspi_pkg::st_rdat:
				if (cnt_zero) next_state = qspi_pkg::st_idle;
			default:
				next_state = qspi_pkg::st_idle;
		endcase
	end

	// wait phase lasts latency+1 sck cycles
	always_comb begin
		case (next_state)
			qspi_pkg::st_cmd:   cnt_load = 4'd7;
			qspi_pkg::st_adr:   cnt_load = 4'd5;
			qspi_pkg::st_wdat:  cnt_load = nib_len(cur.size);
			qspi_pkg::st_rwait: cnt_load = latency_sel;
			qspi_pkg::st_rdat:  cnt_load = nib_len(cur.size);
			default:            cnt_load = 4'd0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= qspi_pkg::st_idle;
			cnt <= 4'd0;
		end else if (fall_tick) begin
			state <= next_state;
			if (next_state != state) begin
				cnt <= cnt_load;
			end else if (!cnt_zero) begin
				cnt <= cnt - 4'd1;
			end
		end
	end

	assign write_data_end = fall_tick & (state == qspi_pkg::st_wdat) & cnt_zero;
	assign read_data_end = fall_tick & (state == qspi_pkg::st_rdat) & cnt_zero;

	assign cmd_byte = (cur.op == qspi_pkg::op_read) ? qspi_pkg::cmd_fread_quad :
	                                                  qspi_pkg::cmd_write_quad;

	// data left aligned so that the nibble pick is the same for every size
	always_comb begin
		case (cur.size)
			qspi_pkg::sz_word: ext_wdata = cur.wdata;
			qspi_pkg::sz_half: ext_wdata = {cur.wdata[15:0], 16'd0};
			default:           ext_wdata = {cur.wdata[7:0], 24'd0};
		endcase
	end

	// low byte first, high nibble of each byte first
	always_comb begin
		case (state)
			qspi_pkg::st_cmd:  sio_out_pre = {3'b000, cmd_byte[cnt[2:0]]};
			qspi_pkg::st_adr:  sio_out_pre = cur.adr[{cnt[2:0], 2'b00} +: 4];
			qspi_pkg::st_wdat: sio_out_pre = ext_wdata[{~cnt[2:1], cnt[0], 2'b00} +: 4];
			default:           sio_out_pre = 4'h0;
		endcase
	end

	assign sio_oe_pre = (state == qspi_pkg::st_cmd) | (state == qspi_pkg::st_adr) |
	                    (state == qspi_pkg::st_wdat);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_out <= 4'h0;
			sio_oe <= 1'b0;
			ce_n <= 3'b111;
		end else begin
			sio_out <= sio_out_pre;
			sio_oe <= sio_oe_pre;
			// chip 3 selects nothing
			ce_n <= (state == qspi_pkg::st_idle) ? 3'b111 : ~(3'b001 << cur.adr[25:24]);
		end
	end

	// synchronizer lags three clocks, so the value at the rising edge
	// is captured on the falling tick that closes the nibble
	always_ff @(posedge clk) begin
		if (fall_tick) begin
			if ((state == qspi_pkg::st_rwait) && cnt_zero) begin
				word_data <= 32'd0;
			end else if (state == qspi_pkg::st_rdat) begin
				word_data <= {word_data[27:0], sio_sync};
			end
		end
	end

	assign rdata_raw = word_data;

	// one clock after the last nibble is in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_read <= 1'b0;
			done_write <= 1'b0;
		end else begin
			done_read <= read_data_end;
			done_write <= write_data_end;
		end
	end

endmodule

// ==== rtl/qspi_cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read latency and sck divider registers on the io bus
// read data comes one cycle after io_radr_en
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_cfg_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] init_latency,
	input  logic io_we,
	input  logic [15:2] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic [15:2] io_radr,
	input  logic io_radr_en,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output logic [3:0] latency0,
	output logic [3:0] latency1,
	output logic [3:0] latency2,
	output logic [9:0] sck_div
);

	logic [3:0] init_value;
	logic [1:0] init_pipe;
	logic init_load;
	logic [3:0] we_dec;
	logic [3:0] re_dec;
	logic [3:0] re_dly;

	// strap code 0..3 gives 7, 8, 9, 6
	always_comb begin
		case (init_latency)
			2'd0:    init_value = 4'd7;
			2'd1:    init_value = 4'd8;
			2'd2:    init_value = 4'd9;
			default: init_value = 4'd6;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_pipe <= 2'b11;
		end else begin
			init_pipe <= {init_pipe[0], 1'b0};
		end
	end

	assign init_load = init_pipe[1];

	assign we_dec = {io_we & (io_wadr == qspi_pkg::reg_sckdiv),
	                 io_we & (io_wadr == qspi_pkg::reg_latency2),
	                 io_we & (io_wadr == qspi_pkg::reg_latency1),
	                 io_we & (io_wadr == qspi_pkg::reg_latency0)};

	assign re_dec = {io_radr_en & (io_radr == qspi_pkg::reg_sckdiv),
	                 io_radr_en & (io_radr == qspi_pkg::reg_latency2),
	                 io_radr_en & (io_radr == qspi_pkg::reg_latency1),
	                 io_radr_en & (io_radr == qspi_pkg::reg_latency0)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			latency0 <= 4'd0;
			latency1 <= 4'd0;
			latency2 <= 4'd0;
		end else if (init_load) begin
			latency0 <= init_value;
			latency1 <= init_value;
			latency2 <= init_value;
		end else begin
			if (we_dec[0]) latency0 <= io_wdata[3:0];
			if (we_dec[1]) latency1 <= io_wdata[3:0];
			if (we_dec[2]) latency2 <= io_wdata[3:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_div <= qspi_pkg::sckdiv_default;
		end else if (we_dec[3]) begin
			sck_div <= io_wdata[9:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			re_dly <= 4'b0000;
		end else begin
			re_dly <= re_dec;
		end
	end

	// other devices on the chain answer through io_rdata_in
	assign io_rdata = re_dly[0] ? {28'd0, latency0} :
	                  re_dly[1] ? {28'd0, latency1} :
	                  re_dly[2] ? {28'd0, latency2} :
	                  re_dly[3] ? {22'd0, sck_div} : io_rdata_in;

endmodule

// ==== rtl/qspi_ctrl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quad-SPI memory controller top
// host strobes, io register bus and split sio pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_ctrl_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] init_latency,
	input  logic read_req,
	input  logic read_w,
	input  logic read_hw,
	input  logic [31:0] read_adr,
	output logic read_valid,
	output logic [31:0] read_data,
	input  logic write_req,
	input  logic write_w,
	input  logic write_hw,
	input  logic [31:0] write_adr,
	input  logic [31:0] write_data,
	output logic write_finish,
	output logic queue_full,
	input  logic io_we,
	input  logic [15:2] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic [15:2] io_radr,
	input  logic io_radr_en,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output logic sck,
	output logic [2:0] ce_n,
	output logic [3:0] sio_out,
	output logic sio_oe,
	input  logic [3:0] sio_in
);

	logic [31:0] rdata_raw;
	logic done_read;
	logic done_write;
	logic [3:0] latency0;
	logic [3:0] latency1;
	logic [3:0] latency2;
	logic [9:0] sck_div;

	qspi_req_if front_if ();
	qspi_req_if seq_if ();

	qspi_host_front #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_front (
		.clk(clk), .rst_n(rst_n),
		.read_req(read_req), .read_w(read_w), .read_hw(read_hw), .read_adr(read_adr),
		.write_req(write_req), .write_w(write_w), .write_hw(write_hw),
		.write_adr(write_adr), .write_data(write_data),
		.rdata_raw(rdata_raw), .done_read(done_read), .done_write(done_write),
		.read_valid(read_valid), .read_data(read_data), .write_finish(write_finish),
		.req_out(front_if.producer)
	);

	qspi_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk(clk), .rst_n(rst_n),
		.push_side(front_if.buffer),
		.pop_side(seq_if.buffer),
		.full(queue_full)
	);

	qspi_sequencer u_seq (
		.clk(clk), .rst_n(rst_n),
		.req_in(seq_if.consumer),
		.latency0(latency0), .latency1(latency1), .latency2(latency2),
		.sck_div(sck_div),
		.sck(sck), .ce_n(ce_n), .sio_out(sio_out), .sio_oe(sio_oe), .sio_in(sio_in),
		.rdata_raw(rdata_raw), .done_read(done_read), .done_write(done_write)
	);

	qspi_cfg_regs u_cfg (
		.clk(clk), .rst_n(rst_n), .init_latency(init_latency),
		.io_we(io_we), .io_wadr(io_wadr), .io_wdata(io_wdata),
		.io_radr(io_radr), .io_radr_en(io_radr_en),
		.io_rdata_in(io_rdata_in), .io_rdata(io_rdata),
		.latency0(latency0), .latency1(latency1), .latency2(latency2),
		.sck_div(sck_div)
	);

endmodule

// ==== test/tb_clkgen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// rst_n low for RESET_CYCLES rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// a real falling edge so the async reset always fires
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== test/qspi_ram_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral quad-SPI serial RAM
// answers EB (quad read) and 38 (quad write) only
// read data starts after WAIT_CYCLES+1 dummy clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_ram_model #(
	parameter int WAIT_CYCLES = 7
) (
	input  logic sck,
	input  logic ce_n,
	input  logic [3:0] sio,
	output logic [3:0] sio_drv,
	output logic sio_drv_en
);

	logic [7:0] mem [int];
	logic [7:0] cmd;
	logic [23:0] adr;
	logic [3:0] hi_nib;
	logic [7:0] rd_byte;
	int rise_cnt;
	int rd_nib;
	int k;

	// unwritten locations read back a pattern of the full address
	function automatic logic [7:0] fetch(input logic [23:0] a);
		if (mem.exists(int'(a))) begin
			return mem[int'(a)];
		end
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
	endfunction

	initial begin
		sio_drv = 4'h0;
		sio_drv_en = 1'b0;
		cmd = 8'h00;
		adr = 24'h0;
		rise_cnt = 0;
		rd_nib = 0;
	end

	// 8 command bits on sio[0], 6 address nibbles, then data
	always @(posedge sck or posedge ce_n) begin
		if (ce_n) begin
			rise_cnt = 0;
		end else begin
			if (rise_cnt < 8) begin
				cmd = {cmd[6:0], sio[0]};
			end else if (rise_cnt < 14) begin
				adr = {adr[19:0], sio};
			end else if (cmd == 8'h38) begin
				k = rise_cnt - 14;
				if (k % 2 == 0) begin
					hi_nib = sio;
				end else begin
					mem[int'(adr + 24'(k / 2))] = {hi_nib, sio};
				end
			end
			rise_cnt = rise_cnt + 1;
		end
	end

	// read nibbles change on falling sck, high nibble first
	always @(negedge sck or posedge ce_n) begin
		if (ce_n) begin
			sio_drv_en = 1'b0;
			rd_nib = 0;
		end else if (cmd == 8'hEB && rise_cnt >= 15 + WAIT_CYCLES) begin
			rd_byte = fetch(adr + 24'(rd_nib / 2));
			sio_drv = (rd_nib % 2 == 1) ? rd_byte[3:0] : rd_byte[7:4];
			sio_drv_en = 1'b1;
			rd_nib = rd_nib + 1;
		end
	end

endmodule

// ==== test/qspi_ctrl_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks bound into the controller top
// fail_count lets the testbench see assertion failures
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module qspi_ctrl_asserts (
	input logic clk,
	input logic rst_n,
	input logic [2:0] ce_n,
	input logic sio_oe,
	input logic sck,
	input logic read_valid,
	input logic write_finish,
	input logic read_req,
	input logic write_req,
	input logic queue_full,
	input qspi_pkg::seq_state_e seq_state
);

	int fail_count = 0;
	logic req_seen;

	// set by the first host strobe after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_seen <= 1'b0;
		end else if (read_req || write_req) begin
			req_seen <= 1'b1;
		end
	end

	ce_one_hot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~ce_n))
		else begin fail_count++; $error("more than one chip select low"); end

	// the bus belongs to the RAM during read nibbles
	no_drive_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		(seq_state == qspi_pkg::st_rdat) |-> !sio_oe)
		else begin fail_count++; $error("sio driven during read data"); end

	one_completion: assert property (@(posedge clk) disable iff (!rst_n)
		!(read_valid && write_finish))
		else begin fail_count++; $error("read and write completion together"); end

	no_strobe_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		(read_req || write_req) |-> !queue_full)
		else begin fail_count++; $error("host strobe while queue full"); end

	reset_levels: assert property (@(posedge clk) !rst_n |->
		(ce_n == 3'b111 && !sio_oe && sck && !read_valid && !write_finish && !queue_full))
		else begin fail_count++; $error("outputs not at reset levels"); end

	idle_until_first_req: assert property (@(posedge clk) disable iff (!rst_n)
		!req_seen |-> (ce_n == 3'b111 && !sio_oe && !read_valid && !write_finish &&
		               !queue_full))
		else begin fail_count++; $error("bus active before the first request"); end

endmodule

bind qspi_ctrl_top qspi_ctrl_asserts u_asserts (
	.clk(clk), .rst_n(rst_n), .ce_n(ce_n), .sio_oe(sio_oe), .sck(sck),
	.read_valid(read_valid), .write_finish(write_finish),
	.read_req(read_req), .write_req(write_req), .queue_full(queue_full),
	.seq_state(u_seq.state)
);

// ==== test/tb_qspi_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the quad-SPI controller with three RAM models
// keeps an expected byte image and checks reads in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_qspi_ctrl;

	// requests x worst request length in sck periods x sck period at div 7
	localparam int REQ_COUNT = 26;
	localparam int REQ_SCK_PERIODS = 48;
	localparam int TIMEOUT_NS = REQ_COUNT * REQ_SCK_PERIODS * 2 * 8 * 8 + 10000;

	logic clk, rst_n;
	logic [1:0] init_latency;
	logic read_req, read_w, read_hw, write_req, write_w, write_hw;
	logic [31:0] read_adr, write_adr, write_data, read_data;
	logic read_valid, write_finish, queue_full;
	logic io_we, io_radr_en;
	logic [15:2] io_wadr, io_radr;
	logic [31:0] io_wdata, io_rdata_in, io_rdata;
	logic sck, sio_oe;
	logic [2:0] ce_n;
	logic [3:0] sio_out, sio_in;
	logic [3:0] m_drv [3];
	logic [2:0] m_en;

	logic [7:0] exp_mem [int];
	logic [31:0] exp_q [$];
	int rd_posted, rd_done, wr_posted, wr_done;
	int errors, base_err, base_assert, tests_run, tests_failed;
	logic full_seen;

	tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst_n(rst_n));

	qspi_ctrl_top #(.QUEUE_DEPTH(4)) dut (
		.clk(clk), .rst_n(rst_n), .init_latency(init_latency),
		.read_req(read_req), .read_w(read_w), .read_hw(read_hw), .read_adr(read_adr),
		.read_valid(read_valid), .read_data(read_data),
		.write_req(write_req), .write_w(write_w), .write_hw(write_hw),
		.write_adr(write_adr), .write_data(write_data), .write_finish(write_finish),
		.queue_full(queue_full),
		.io_we(io_we), .io_wadr(io_wadr), .io_wdata(io_wdata),
		.io_radr(io_radr), .io_radr_en(io_radr_en),
		.io_rdata_in(io_rdata_in), .io_rdata(io_rdata),
		.sck(sck), .ce_n(ce_n), .sio_out(sio_out), .sio_oe(sio_oe), .sio_in(sio_in)
	);

	qspi_ram_model #(.WAIT_CYCLES(7)) u_ram0 (.sck(sck), .ce_n(ce_n[0]), .sio(sio_in),
		.sio_drv(m_drv[0]), .sio_drv_en(m_en[0]));
	qspi_ram_model #(.WAIT_CYCLES(8)) u_ram1 (.sck(sck), .ce_n(ce_n[1]), .sio(sio_in),
		.sio_drv(m_drv[1]), .sio_drv_en(m_en[1]));
	qspi_ram_model #(.WAIT_CYCLES(9)) u_ram2 (.sck(sck), .ce_n(ce_n[2]), .sio(sio_in),
		.sio_drv(m_drv[2]), .sio_drv_en(m_en[2]));

	assign sio_in = sio_oe ? sio_out : m_en[0] ? m_drv[0] : m_en[1] ? m_drv[1] :
	                m_en[2] ? m_drv[2] : 4'h0;

	function automatic logic [7:0] exp_byte(input logic [25:0] a);
		if (exp_mem.exists(int'(a))) begin
			return exp_mem[int'(a)];
		end
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// completions come back in request order
	always @(posedge clk) begin
		if (rst_n) begin
			if (queue_full) full_seen = 1'b1;
			if (write_finish) wr_done++;
			if (read_valid) begin
				if (exp_q.size() == 0) begin
					$display("read completion arrived with no read outstanding");
					errors++;
				end else begin
					check_value("read_data", read_data, exp_q.pop_front());
				end
				rd_done++;
			end
		end
	end

	// three clocks between strobes so queue_full is current when sampled
	task automatic wait_slot();
		@(posedge clk);
		while (queue_full) @(posedge clk);
	endtask

	task automatic post_write(input int nbytes, input logic [25:0] adr,
	                          input logic [31:0] data);
		int i;
		wait_slot();
		write_req <= 1'b1;
		write_w <= (nbytes == 4);
		write_hw <= (nbytes == 2);
		write_adr <= {6'd0, adr};
		write_data <= data;
		for (i = 0; i < nbytes; i++) exp_mem[int'(adr + 26'(i))] = data[8*i +: 8];
		wr_posted++;
		@(posedge clk);
		write_req <= 1'b0;
		@(posedge clk);
	endtask

	task automatic post_read(input int nbytes, input logic [25:0] adr);
		logic [31:0] exp;
		int i;
		exp = '0;
		for (i = 0; i < nbytes; i++) exp[8*i +: 8] = exp_byte(adr + 26'(i));
		wait_slot();
		read_req <= 1'b1;
		read_w <= (nbytes == 4);
		read_hw <= (nbytes == 2);
		read_adr <= {6'd0, adr};
		exp_q.push_back(exp);
		rd_posted++;
		@(posedge clk);
		read_req <= 1'b0;
		@(posedge clk);
	endtask

	task automatic wait_all();
		while (rd_done < rd_posted || wr_done < wr_posted) @(posedge clk);
		@(posedge clk);
	endtask

	task automatic reg_write(input logic [13:0] off, input logic [31:0] value);
		@(posedge clk);
		io_we <= 1'b1;
		io_wadr <= off;
		io_wdata <= value;
		@(posedge clk);
		io_we <= 1'b0;
	endtask

	task automatic reg_check(input logic [13:0] off, input logic [31:0] exp);
		logic [31:0] chain;
		chain = $urandom;
		@(posedge clk);
		io_radr_en <= 1'b1;
		io_radr <= off;
		io_rdata_in <= chain;
		@(posedge clk);
		check_value("io_rdata", io_rdata, chain);
		io_radr_en <= 1'b0;
		@(posedge clk);
		check_value("io_rdata", io_rdata, exp);
		@(posedge clk);
		check_value("io_rdata", io_rdata, chain);
	endtask

	task automatic check_half_period(input int exp);
		logic prev;
		int n;
		repeat (2) begin
			prev = sck;
			@(posedge clk);
			while (sck == prev) @(posedge clk);
		end
		prev = sck;
		n = 0;
		while (sck == prev) begin
			@(posedge clk);
			n++;
		end
		check_value("sck half period", 32'(n), 32'(exp));
	endtask

	task automatic begin_test();
		base_err = errors;
		base_assert = dut.u_asserts.fail_count;
	endtask

	task automatic end_test(input string name);
		int n;
		n = (errors - base_err) + (dut.u_asserts.fail_count - base_assert);
		tests_run++;
		if (n == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, n);
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: requests did not complete in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		logic [25:0] a;
		int i;
		int sizes [3];
		void'($urandom(76));
		sizes = '{1, 2, 4};
		init_latency = 2'd0;
		read_req = 1'b0;
		read_w = 1'b0;
		read_hw = 1'b0;
		read_adr = '0;
		write_req = 1'b0;
		write_w = 1'b0;
		write_hw = 1'b0;
		write_adr = '0;
		write_data = '0;
		io_we = 1'b0;
		io_wadr = '0;
		io_wdata = '0;
		io_radr = '0;
		io_radr_en = 1'b0;
		io_rdata_in = '0;
		rd_posted = 0;
		rd_done = 0;
		wr_posted = 0;
		wr_done = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		full_seen = 1'b0;
		@(posedge rst_n);

		begin_test();
		repeat (40) @(posedge clk);
		end_test("idle levels after reset");

		begin_test();
		reg_write(qspi_pkg::reg_latency0, 32'd7);
		reg_write(qspi_pkg::reg_latency1, 32'd8);
		reg_write(qspi_pkg::reg_latency2, 32'd9);
		for (i = 0; i < 3; i++) begin
			a = {2'(i), 24'h000040};
			post_write(4, a, $urandom);
			post_read(4, a);
		end
		wait_all();
		end_test("word write and read on each chip");

		begin_test();
		a = {2'd1, 24'h000100};
		post_write(1, a + 26'd1, $urandom);
		post_write(2, a + 26'd6, $urandom);
		post_read(1, a + 26'd1);
		post_read(2, a + 26'd6);
		post_read(4, a);
		post_read(4, a + 26'd4);
		post_read(1, a + 26'd3);
		a = {2'd2, 24'h000020};
		post_write(2, a, $urandom);
		post_read(4, a);
		post_read(2, a);
		wait_all();
		end_test("byte and halfword access");

		begin_test();
		reg_check(qspi_pkg::reg_latency0, 32'd7);
		reg_check(qspi_pkg::reg_latency1, 32'd8);
		reg_check(qspi_pkg::reg_latency2, 32'd9);
		reg_check(qspi_pkg::reg_sckdiv, 32'd3);
		end_test("register read-back");

		begin_test();
		reg_write(qspi_pkg::reg_sckdiv, 32'd1);
		check_half_period(2);
		post_write(4, 26'h0000200, $urandom);
		post_read(4, 26'h0000200);
		wait_all();
		reg_write(qspi_pkg::reg_sckdiv, 32'd7);
		check_half_period(8);
		post_write(4, {2'd2, 24'h000300}, $urandom);
		post_read(4, {2'd2, 24'h000300});
		wait_all();
		reg_write(qspi_pkg::reg_sckdiv, 32'd3);
		end_test("sck divider");

		begin_test();
		full_seen = 1'b0;
		for (i = 0; i < 6; i++) begin
			a = {2'($urandom % 3), 24'h004000 | (24'($urandom) & 24'h000FFC)};
			if ($urandom % 2 == 0) begin
				post_write(sizes[$urandom % 3], a, $urandom);
			end else begin
				post_read(sizes[$urandom % 3], a);
			end
		end
		wait_all();
		if (!full_seen) begin
			$display("queue_full never rose while requests were posted");
			errors++;
		end
		end_test("posted random requests");

		$display("tests run %0d, passed %0d, failed %0d",
		         tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && errors == 0 && dut.u_asserts.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/qspi_pkg.sv
rtl/qspi_req_if.sv
rtl/qspi_host_front.sv
rtl/qspi_req_queue.sv
rtl/qspi_sequencer.sv
rtl/qspi_cfg_regs.sv
rtl/qspi_ctrl_top.sv
test/tb_clkgen.sv
test/qspi_ram_model.sv
test/qspi_ctrl_asserts.sv
test/tb_qspi_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_qspi_ctrl \
	-f flist.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
